//--- cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data memory size in 32-bit words
`define CPU_DMEM_WORDS 256

// First fetch address once reset is released
`define CPU_RESET_PC 32'h0000_0000

// Younger instructions squashed when a branch resolves in memory
// One per stage between fetch and memory
`define CPU_BRANCH_FLUSH 3

`endif

//--- isaPkg.sv
package isaPkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_t;

  // funct3 of the register and immediate ALU instructions
  typedef enum logic [2:0] {
    F3_ADD = 3'b000,
    F3_SLT = 3'b010,
    F3_XOR = 3'b100,
    F3_OR  = 3'b110,
    F3_AND = 3'b111
  } aluFunct3_t;

  // funct3 of the two supported branches
  typedef enum logic [2:0] {
    F3_BEQ = 3'b000,
    F3_BNE = 3'b001
  } branchFunct3_t;

  typedef logic [6:0] funct7_t;

  typedef enum logic [3:0] {ADD, SUB, AND, OR, XOR, SLT} aluOp_t;

  // How execute picks the ALU operation
  typedef enum logic [1:0] {ADDR, BRCMP, FUNCT} aluClass_t;

endpackage

//--- pipePkg.sv
package pipePkg;

  // Data word and byte address
  typedef logic [31:0] word_t;

  // Architectural register index
  typedef logic [4:0] regAddr_t;

  // Source of an execute-stage operand
  typedef enum logic [1:0] {
    FROM_REG = 2'd0,
    FROM_WB  = 2'd1,
    FROM_MEM = 2'd2
  } fwdSel_t;

endpackage

//--- hazardIf.sv
`timescale 1ns/1ps

interface hazardIf;
  // Hold enables, low keeps the register contents
  logic writePc;
  logic writeIfId;
  logic writeIdEx;

  // Zero the control fields of the named pipeline register
  logic flushIfId;
  logic flushIdEx;
  logic flushExMem;

  modport unit (
    output writePc, writeIfId, writeIdEx,
    output flushIfId, flushIdEx, flushExMem
  );

  modport pipe (
    input writePc, writeIfId, writeIdEx,
    input flushIfId, flushIdEx, flushExMem
  );
endinterface

//--- decoder.sv
`timescale 1ns/1ps

module decoder (
  input  pipePkg::word_t     instr,
  output pipePkg::word_t     imm,
  output isaPkg::aluClass_t  aluClass,
  output logic               aluSrcImm,
  output logic               memRead,
  output logic               memWrite,
  output logic               memToReg,
  output logic               regWrite,
  output logic               branchEq,
  output logic               branchNe,
  output logic               jump,
  output logic               linkWrite
);

  logic [2:0] funct3;
  logic branch;
  pipePkg::word_t immI, immS, immB, immJ;

  assign funct3 = instr[14:12];

  // Sign-extended immediates of each format
  assign immI = {{20{instr[31]}}, instr[31:20]};
  assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb
  begin
    imm       = '0;
    aluClass  = isaPkg::ADDR;
    aluSrcImm = 1'b0;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    memToReg  = 1'b0;
    regWrite  = 1'b0;
    branch    = 1'b0;
    jump      = 1'b0;
    linkWrite = 1'b0;
    case (instr[6:0])
      isaPkg::OP:
      begin
        aluClass = isaPkg::FUNCT;
        regWrite = 1'b1;
      end
      isaPkg::OP_IMM:
      begin
        imm       = immI;
        aluClass  = isaPkg::FUNCT;
        aluSrcImm = 1'b1;
        regWrite  = 1'b1;
      end
      isaPkg::LOAD:
      begin
        imm       = immI;
        aluSrcImm = 1'b1;
        memRead   = 1'b1;
        memToReg  = 1'b1;
        regWrite  = 1'b1;
      end
      isaPkg::STORE:
      begin
        imm       = immS;
        aluSrcImm = 1'b1;
        memWrite  = 1'b1;
      end
      isaPkg::BRANCH:
      begin
        imm      = immB;
        aluClass = isaPkg::BRCMP;
        branch   = 1'b1;
      end
      isaPkg::JAL:
      begin
        imm       = immJ;
        jump      = 1'b1;
        regWrite  = 1'b1;
        linkWrite = 1'b1;
      end
      default:
        imm = '0;
    endcase
  end

  // Other branch encodings fall through as no-ops
  assign branchEq = branch && (funct3 == isaPkg::F3_BEQ);
  assign branchNe = branch && (funct3 == isaPkg::F3_BNE);

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
  input  isaPkg::aluClass_t aluClass,
  input  logic [2:0]        funct3,
  input  isaPkg::funct7_t   funct7,
  input  pipePkg::word_t    inA,
  input  pipePkg::word_t    inB,
  output pipePkg::word_t    result,
  output logic              zero
);

  isaPkg::aluOp_t op;

  // Operation select
  always_comb
  begin
    case (aluClass)
      isaPkg::ADDR:  op = isaPkg::ADD;
      isaPkg::BRCMP: op = isaPkg::SUB;
      default:
        case (funct3)
          isaPkg::F3_ADD: op = funct7[5] ? isaPkg::SUB : isaPkg::ADD;
          isaPkg::F3_SLT: op = isaPkg::SLT;
          isaPkg::F3_XOR: op = isaPkg::XOR;
          isaPkg::F3_OR:  op = isaPkg::OR;
          isaPkg::F3_AND: op = isaPkg::AND;
          default:        op = isaPkg::ADD;
        endcase
    endcase
  end

  always_comb
  begin
    case (op)
      isaPkg::SUB: result = inA - inB;
      isaPkg::AND: result = inA & inB;
      isaPkg::OR:  result = inA | inB;
      isaPkg::XOR: result = inA ^ inB;
      // Signed compare for slt
      isaPkg::SLT: result = {31'b0, $signed(inA) < $signed(inB)};
      default:     result = inA + inB;
    endcase
  end

  // Branch compare result, checked in the memory stage
  assign zero = (result == '0);

endmodule

//--- regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic              clock,
  input  logic              reset,
  input  pipePkg::regAddr_t readAddrA,
  input  pipePkg::regAddr_t readAddrB,
  input  pipePkg::regAddr_t writeAddr,
  input  logic              writeEnable,
  input  pipePkg::word_t    writeData,
  output pipePkg::word_t    readDataA,
  output pipePkg::word_t    readDataB
);

  pipePkg::word_t regs [32];
  logic bypassA, bypassB;

  // x0 is never written so it reads as zero
  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (writeEnable && (writeAddr != '0))
      regs[writeAddr] <= writeData;
  end

  // Same-cycle write shows up on the read ports
  assign bypassA = writeEnable && (writeAddr != '0) && (writeAddr == readAddrA);
  assign bypassB = writeEnable && (writeAddr != '0) && (writeAddr == readAddrB);

  assign readDataA = bypassA ? writeData : regs[readAddrA];
  assign readDataB = bypassB ? writeData : regs[readAddrB];

endmodule

//--- bypassUnit.sv
`timescale 1ns/1ps

module bypassUnit (
  input  pipePkg::regAddr_t rs1,
  input  pipePkg::regAddr_t rs2,
  input  pipePkg::regAddr_t memRd,
  input  pipePkg::regAddr_t wbRd,
  input  logic              memRegWrite,
  input  logic              wbRegWrite,
  output pipePkg::fwdSel_t  selA,
  output pipePkg::fwdSel_t  selB
);

  // Newest producer wins, so memory beats writeback
  function automatic pipePkg::fwdSel_t pick(input pipePkg::regAddr_t rs);
    if (memRegWrite && (memRd != '0) && (memRd == rs))
      return pipePkg::FROM_MEM;
    else if (wbRegWrite && (wbRd != '0) && (wbRd == rs))
      return pipePkg::FROM_WB;
    else
      return pipePkg::FROM_REG;
  endfunction

  assign selA = pick(rs1);
  assign selB = pick(rs2);

endmodule

//--- hazardUnit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module hazardUnit (
  input  pipePkg::regAddr_t decRs1,
  input  pipePkg::regAddr_t decRs2,
  input  pipePkg::regAddr_t exRd,
  input  logic              exMemRead,
  input  logic              decJump,
  input  logic              memBranchTaken,
  hazardIf.unit             ctrl
);

  logic loadUse;
  // Bit 0 is IF/ID, then ID/EX, then EX/MEM
  logic [`CPU_BRANCH_FLUSH-1:0] squash;

  // jal reads no registers, its rs fields are immediate bits
  assign loadUse = exMemRead && (exRd != '0) && !decJump &&
                   ((exRd == decRs1) || (exRd == decRs2));

  assign squash = {`CPU_BRANCH_FLUSH{memBranchTaken}};

  // A taken branch overrides the stall and loads its target
  assign ctrl.writePc   = !loadUse || memBranchTaken;
  assign ctrl.writeIfId = !loadUse;
  assign ctrl.writeIdEx = !loadUse;

  assign ctrl.flushIfId  = squash[0] || decJump;
  assign ctrl.flushIdEx  = squash[1] || loadUse;
  assign ctrl.flushExMem = squash[`CPU_BRANCH_FLUSH-1];

endmodule

//--- dataMemory.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module dataMemory (
  input  logic           clock,
  input  logic           readEnable,
  input  logic           writeEnable,
  input  pipePkg::word_t addr,
  input  pipePkg::word_t writeData,
  output pipePkg::word_t readData
);

  pipePkg::word_t mem [`CPU_DMEM_WORDS];
  logic [$clog2(`CPU_DMEM_WORDS)-1:0] index;

  // Word index, upper address bits wrap around
  assign index = addr[$clog2(`CPU_DMEM_WORDS)+1:2];

  always_ff @(posedge clock)
  begin
    if (writeEnable)
      mem[index] <= writeData;
  end

  assign readData = readEnable ? mem[index] : '0;

endmodule

//--- cpu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu (
  input  logic              clock,
  input  logic              reset,
  output pipePkg::word_t    imemAddr,
  input  pipePkg::word_t    imemData,
  output logic              regWriteValid,
  output pipePkg::regAddr_t regWriteAddr,
  output pipePkg::word_t    regWriteData,
  output logic              storeValid,
  output pipePkg::word_t    storeAddr,
  output pipePkg::word_t    storeData
);

  hazardIf hazard ();

  // Fetch and IF/ID
  pipePkg::word_t pc, pcPlus4, pcNext, jumpTarget, ifIdPc, ifIdInstr;
  // Decode
  pipePkg::regAddr_t decRs1, decRs2;
  pipePkg::word_t decImm, decRs1Data, decRs2Data;
  isaPkg::aluClass_t decAluClass;
  logic decAluSrcImm, decMemRead, decMemWrite, decMemToReg, decRegWrite;
  logic decBranchEq, decBranchNe, decJump, decLinkWrite, keepIdEx;
  // ID/EX
  isaPkg::aluClass_t idExAluClass;
  logic idExAluSrcImm, idExMemRead, idExMemWrite, idExMemToReg, idExRegWrite;
  logic idExBranchEq, idExBranchNe, idExLinkWrite;
  pipePkg::word_t idExPc, idExImm, idExRs1Data, idExRs2Data;
  pipePkg::regAddr_t idExRs1, idExRs2, idExRd;
  logic [2:0] idExFunct3;
  isaPkg::funct7_t idExFunct7;
  // Execute
  pipePkg::fwdSel_t selA, selB;
  pipePkg::word_t fwdA, fwdB, aluInB, aluResult;
  logic aluZero;
  // EX/MEM and memory stage
  logic exMemMemRead, exMemMemWrite, exMemMemToReg, exMemRegWrite;
  logic exMemBranchEq, exMemBranchNe, exMemLinkWrite, exMemZero, memBranchTaken;
  pipePkg::word_t exMemAluResult, exMemStoreData, exMemPcPlus4, exMemBranchTarget;
  pipePkg::word_t memReadData, memFwdData;
  pipePkg::regAddr_t exMemRd;
  // MEM/WB and writeback
  logic memWbRegWrite, memWbMemToReg, memWbLinkWrite;
  pipePkg::word_t memWbAluResult, memWbLoadData, memWbPcPlus4, wbData;
  pipePkg::regAddr_t memWbRd;

  function automatic pipePkg::word_t forward(input pipePkg::fwdSel_t sel,
                                             input pipePkg::word_t regData,
                                             input pipePkg::word_t memData,
                                             input pipePkg::word_t wbValue);
    case (sel)
      pipePkg::FROM_MEM: return memData;
      pipePkg::FROM_WB:  return wbValue;
      default:           return regData;
    endcase
  endfunction

  assign imemAddr   = pc;
  assign pcPlus4    = pc + 32'd4;
  assign jumpTarget = ifIdPc + decImm;

  // Taken branch is older than a jump in decode
  always_comb
  begin
    if (memBranchTaken)
      pcNext = exMemBranchTarget;
    else if (decJump)
      pcNext = jumpTarget;
    else
      pcNext = pcPlus4;
  end

  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
      pc <= `CPU_RESET_PC;
    else if (hazard.writePc)
      pc <= pcNext;
  end

  // A zero instruction word decodes as a no-op
  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
      ifIdInstr <= '0;
    else if (hazard.flushIfId)
      ifIdInstr <= '0;
    else if (hazard.writeIfId)
      ifIdInstr <= imemData;
  end

  assign decRs1 = ifIdInstr[19:15];
  assign decRs2 = ifIdInstr[24:20];

  decoder decodeUnit (
    .instr(ifIdInstr), .imm(decImm), .aluClass(decAluClass), .aluSrcImm(decAluSrcImm),
    .memRead(decMemRead), .memWrite(decMemWrite), .memToReg(decMemToReg),
    .regWrite(decRegWrite), .branchEq(decBranchEq), .branchNe(decBranchNe),
    .jump(decJump), .linkWrite(decLinkWrite)
  );

  regFile regs (
    .clock, .reset, .readAddrA(decRs1), .readAddrB(decRs2), .writeAddr(memWbRd),
    .writeEnable(memWbRegWrite), .writeData(wbData),
    .readDataA(decRs1Data), .readDataB(decRs2Data)
  );

  hazardUnit hazards (
    .decRs1, .decRs2, .exRd(idExRd), .exMemRead(idExMemRead), .decJump,
    .memBranchTaken, .ctrl(hazard.unit)
  );

  // ID/EX controls, a flush loads a bubble
  assign keepIdEx = !hazard.flushIdEx;

  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
    begin
      idExAluClass  <= isaPkg::ADDR;
      idExAluSrcImm <= 1'b0;
      idExMemRead   <= 1'b0;
      idExMemWrite  <= 1'b0;
      idExMemToReg  <= 1'b0;
      idExRegWrite  <= 1'b0;
      idExBranchEq  <= 1'b0;
      idExBranchNe  <= 1'b0;
      idExLinkWrite <= 1'b0;
    end
    else if (hazard.writeIdEx || hazard.flushIdEx)
    begin
      idExAluClass  <= keepIdEx ? decAluClass : isaPkg::ADDR;
      idExAluSrcImm <= decAluSrcImm && keepIdEx;
      idExMemRead   <= decMemRead && keepIdEx;
      idExMemWrite  <= decMemWrite && keepIdEx;
      idExMemToReg  <= decMemToReg && keepIdEx;
      idExRegWrite  <= decRegWrite && keepIdEx;
      idExBranchEq  <= decBranchEq && keepIdEx;
      idExBranchNe  <= decBranchNe && keepIdEx;
      idExLinkWrite <= decLinkWrite && keepIdEx;
    end
  end

  bypassUnit bypass (
    .rs1(idExRs1), .rs2(idExRs2), .memRd(exMemRd), .wbRd(memWbRd),
    .memRegWrite(exMemRegWrite), .wbRegWrite(memWbRegWrite), .selA, .selB
  );

  assign fwdA   = forward(selA, idExRs1Data, memFwdData, wbData);
  assign fwdB   = forward(selB, idExRs2Data, memFwdData, wbData);
  assign aluInB = idExAluSrcImm ? idExImm : fwdB;

  alu aluUnit (
    .aluClass(idExAluClass), .funct3(idExFunct3), .funct7(idExFunct7),
    .inA(fwdA), .inB(aluInB), .result(aluResult), .zero(aluZero)
  );

  // EX/MEM and MEM/WB controls
  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
    begin
      exMemMemRead   <= 1'b0;
      exMemMemWrite  <= 1'b0;
      exMemMemToReg  <= 1'b0;
      exMemRegWrite  <= 1'b0;
      exMemBranchEq  <= 1'b0;
      exMemBranchNe  <= 1'b0;
      exMemLinkWrite <= 1'b0;
      memWbRegWrite  <= 1'b0;
      memWbMemToReg  <= 1'b0;
      memWbLinkWrite <= 1'b0;
    end
    else
    begin
      exMemMemRead   <= idExMemRead && !hazard.flushExMem;
      exMemMemWrite  <= idExMemWrite && !hazard.flushExMem;
      exMemMemToReg  <= idExMemToReg && !hazard.flushExMem;
      exMemRegWrite  <= idExRegWrite && !hazard.flushExMem;
      exMemBranchEq  <= idExBranchEq && !hazard.flushExMem;
      exMemBranchNe  <= idExBranchNe && !hazard.flushExMem;
      exMemLinkWrite <= idExLinkWrite && !hazard.flushExMem;
      memWbRegWrite  <= exMemRegWrite;
      memWbMemToReg  <= exMemMemToReg;
      memWbLinkWrite <= exMemLinkWrite;
    end
  end

  // Payload of all pipeline registers
  always_ff @(posedge clock)
  begin
    if (hazard.writeIfId)
      ifIdPc <= pc;
    if (hazard.writeIdEx)
    begin
      idExPc      <= ifIdPc;
      idExImm     <= decImm;
      idExRs1Data <= decRs1Data;
      idExRs2Data <= decRs2Data;
      idExRs1     <= decRs1;
      idExRs2     <= decRs2;
      idExRd      <= ifIdInstr[11:7];
      idExFunct3  <= ifIdInstr[14:12];
      // Immediate bits there must not turn addi into a subtract
      idExFunct7  <= decAluSrcImm ? '0 : ifIdInstr[31:25];
    end
    exMemAluResult    <= aluResult;
    exMemZero         <= aluZero;
    exMemStoreData    <= fwdB;
    exMemRd           <= idExRd;
    exMemPcPlus4      <= idExPc + 32'd4;
    exMemBranchTarget <= idExPc + idExImm;
    memWbAluResult    <= exMemAluResult;
    memWbLoadData     <= memReadData;
    memWbRd           <= exMemRd;
    memWbPcPlus4      <= exMemPcPlus4;
  end

  // Memory stage
  assign memFwdData     = exMemLinkWrite ? exMemPcPlus4 : exMemAluResult;
  assign memBranchTaken = (exMemBranchEq && exMemZero) || (exMemBranchNe && !exMemZero);

  dataMemory dmem (
    .clock, .readEnable(exMemMemRead), .writeEnable(exMemMemWrite),
    .addr(exMemAluResult), .writeData(exMemStoreData), .readData(memReadData)
  );

  assign storeValid = exMemMemWrite;
  assign storeAddr  = exMemAluResult;
  assign storeData  = exMemStoreData;

  // Writeback
  assign wbData = memWbLinkWrite ? memWbPcPlus4 :
                  (memWbMemToReg ? memWbLoadData : memWbAluResult);

  assign regWriteValid = memWbRegWrite && (memWbRd != '0);
  assign regWriteAddr  = memWbRd;
  assign regWriteData  = wbData;

endmodule

//--- tbCpu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module tbCpu;

  localparam int TEST_COUNT = 6;
  // Instructions over all tests with the restart program counted twice
  localparam int PROGRAM_WORDS = 13 + 9 + 24 + 9 + 81 + 2 * 9;
  localparam int RANDOM_COUNT = 64;
  localparam longint WATCHDOG_NS = (PROGRAM_WORDS * 40 + TEST_COUNT * 64) * 10;

  logic clock;
  logic reset;
  pipePkg::word_t imemAddr;
  pipePkg::word_t imemData;
  logic regWriteValid;
  pipePkg::regAddr_t regWriteAddr;
  pipePkg::word_t regWriteData;
  logic storeValid;
  pipePkg::word_t storeAddr;
  pipePkg::word_t storeData;

  pipePkg::word_t imem [128];
  int progLen;
  pipePkg::word_t refRegs [32];
  pipePkg::word_t refMem [`CPU_DMEM_WORDS];
  // Store flag, then address or register, then data
  logic [64:0] expected [$];
  logic [31:0] lfsr = 32'ha849_f61a;
  int errors = 0;
  int extras = 0;
  int checked = 0;
  int failedTests = 0;
  int testNum = 0;
  int fillReg;

  cpu cpu_inst (
    .clock, .reset, .imemAddr, .imemData, .regWriteValid, .regWriteAddr,
    .regWriteData, .storeValid, .storeAddr, .storeData
  );

  always #5 clock = ~clock;

  assign imemData = imem[imemAddr[8:2]];

  function automatic logic [31:0] nextBits(input int n);
    logic [31:0] value;
    logic feedback;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      // Taps 32, 22, 2 and 1
      feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], feedback};
      value = {value[30:0], feedback};
    end
    return value;
  endfunction

  function automatic pipePkg::word_t rType(input logic [2:0] f3, input isaPkg::funct7_t f7,
      input pipePkg::regAddr_t rd, input pipePkg::regAddr_t rs1, input pipePkg::regAddr_t rs2);
    return {f7, rs2, rs1, f3, rd, isaPkg::OP};
  endfunction

  function automatic pipePkg::word_t iType(input isaPkg::opcode_t op, input logic [2:0] f3,
      input pipePkg::regAddr_t rd, input pipePkg::regAddr_t rs1, input logic [31:0] imm);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic pipePkg::word_t sType(input pipePkg::regAddr_t rs2,
      input pipePkg::regAddr_t rs1, input logic [31:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], isaPkg::STORE};
  endfunction

  function automatic pipePkg::word_t bType(input logic [2:0] f3, input pipePkg::regAddr_t rs1,
      input pipePkg::regAddr_t rs2, input logic [31:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], isaPkg::BRANCH};
  endfunction

  function automatic pipePkg::word_t jType(input pipePkg::regAddr_t rd, input logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, isaPkg::JAL};
  endfunction

  function automatic pipePkg::word_t addi(input pipePkg::regAddr_t rd,
      input pipePkg::regAddr_t rs1, input logic [31:0] imm);
    return iType(isaPkg::OP_IMM, isaPkg::F3_ADD, rd, rs1, imm);
  endfunction

  function automatic pipePkg::word_t lw(input pipePkg::regAddr_t rd,
      input pipePkg::regAddr_t rs1, input logic [31:0] imm);
    return iType(isaPkg::LOAD, 3'b010, rd, rs1, imm);
  endfunction

  function automatic void emit(input pipePkg::word_t word);
    imem[progLen] = word;
    progLen++;
  endfunction

  // Zero words decode as no-ops
  function automatic void clearProgram();
    for (int i = 0; i < 128; i++)
      imem[i] = '0;
    progLen = 0;
  endfunction

  function automatic pipePkg::word_t refAlu(input logic [2:0] f3, input logic sub,
      input pipePkg::word_t a, input pipePkg::word_t b);
    isaPkg::aluOp_t op;
    case (f3)
      3'b000:  op = sub ? isaPkg::SUB : isaPkg::ADD;
      3'b010:  op = isaPkg::SLT;
      3'b100:  op = isaPkg::XOR;
      3'b110:  op = isaPkg::OR;
      default: op = isaPkg::AND;
    endcase
    case (op)
      isaPkg::ADD: return a + b;
      isaPkg::SUB: return a - b;
      isaPkg::SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      isaPkg::XOR: return a ^ b;
      isaPkg::OR:  return a | b;
      default:     return a & b;
    endcase
  endfunction

  function automatic void expectWrite(input pipePkg::regAddr_t rd, input pipePkg::word_t value);
    // x0 stays zero and never pulses
    if (rd != 5'd0)
    begin
      refRegs[rd] = value;
      expected.push_back({1'b0, 27'd0, rd, value});
    end
  endfunction

  function automatic void expectStore(input pipePkg::word_t addr, input pipePkg::word_t value);
    refMem[(addr >> 2) % `CPU_DMEM_WORDS] = value;
    expected.push_back({1'b1, addr, value});
  endfunction

  // Runs the loaded program from reset up to its closing self-jump
  function automatic void runReference();
    pipePkg::word_t pc, ins, a, b, immI, immS, immB, immJ;
    logic [2:0] f3;
    pipePkg::regAddr_t rd;
    for (int i = 0; i < 32; i++)
      refRegs[i] = '0;
    pc = `CPU_RESET_PC;
    for (int step = 0; step < 1000; step++)
    begin
      ins = imem[pc[8:2]];
      if (ins == jType(5'd0, 32'd0))
        break;
      a = refRegs[ins[19:15]];
      b = refRegs[ins[24:20]];
      f3 = ins[14:12];
      rd = ins[11:7];
      immI = {{20{ins[31]}}, ins[31:20]};
      immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      case (ins[6:0])
        isaPkg::OP:     expectWrite(rd, refAlu(f3, ins[30], a, b));
        isaPkg::OP_IMM: expectWrite(rd, refAlu(f3, 1'b0, a, immI));
        isaPkg::LOAD:   expectWrite(rd, refMem[((a + immI) >> 2) % `CPU_DMEM_WORDS]);
        isaPkg::STORE:  expectStore(a + immS, b);
        default:        ;
      endcase
      if (ins[6:0] == isaPkg::JAL)
      begin
        expectWrite(rd, pc + 32'd4);
        pc = pc + immJ;
      end
      // beq takes equal operands, bne the others
      else if ((ins[6:0] == isaPkg::BRANCH) && ((f3 == 3'b000) == (a == b)))
        pc = pc + immB;
      else
        pc = pc + 32'd4;
    end
  endfunction

  task automatic check(input logic [64:0] got, input logic [64:0] want, input string what);
    if (got !== want)
    begin
      errors++;
      $display("ERR %0t: %s mismatch, got %h expected %h", $time, what, got, want);
    end
  endtask

  task automatic logPulse(input logic [64:0] got, input string what);
    if (expected.size() == 0)
    begin
      errors++;
      extras++;
      $display("Unexpected %s pulse at %0t with nothing left to retire", what, $time);
    end
    else
    begin
      checked++;
      check(got, expected.pop_front(), what);
    end
  endtask

  // Older instruction sits in writeback, so its write comes before the store
  always @(negedge clock)
  begin
    if (!reset)
    begin
      if ((regWriteValid !== 1'b0) || (storeValid !== 1'b0))
      begin
        errors++;
        $display("A write or store strobe was active during reset at %0t", $time);
      end
    end
    else
    begin
      if (regWriteValid)
        logPulse({1'b0, 27'd0, regWriteAddr, regWriteData}, "register write");
      if (storeValid)
        logPulse({1'b1, storeAddr, storeData}, "store");
    end
  end

  task automatic holdReset();
    @(posedge clock);
    #1 reset = 1'b0;
    repeat (2) @(posedge clock);
    #1;
  endtask

  task automatic runProgram(input string name, input int interruptAfter);
    int errorsBefore, extrasBefore, checkedBefore, limit, cycles, total, missing;
    errorsBefore = errors;
    extrasBefore = extras;
    checkedBefore = checked;
    testNum++;
    limit = 40 * progLen;
    runReference();
    check({33'd0, imemAddr}, {33'd0, `CPU_RESET_PC}, "fetch address in reset");
    reset = 1'b1;
    if (interruptAfter > 0)
    begin
      total = expected.size();
      cycles = 0;
      while ((total - expected.size() < interruptAfter) && (cycles < limit))
      begin
        @(posedge clock);
        cycles++;
      end
      // Reset in mid program, then start over
      holdReset();
      expected.delete();
      runReference();
      check({33'd0, imemAddr}, {33'd0, `CPU_RESET_PC}, "fetch address in reset");
      reset = 1'b1;
    end
    cycles = 0;
    while ((expected.size() > 0) && (cycles < limit))
    begin
      @(posedge clock);
      cycles++;
    end
    // Room for stray pulses
    repeat (20) @(posedge clock);
    missing = expected.size();
    if (missing > 0)
    begin
      errors += missing;
      $display("Test %0d %s: %0d expected writes or stores never appeared",
               testNum, name, missing);
      expected.delete();
    end
    if (errors == errorsBefore)
      $display("Test %0d %s: pass, %0d retired", testNum, name, checked - checkedBefore);
    else
    begin
      failedTests++;
      $display("Test %0d %s: fail, %0d retired, %0d missing, %0d extra", testNum, name,
               checked - checkedBefore, missing, extras - extrasBefore);
    end
  endtask

  task automatic chainProgram();
    clearProgram();
    emit(addi(5'd1, 5'd0, 5));
    emit(addi(5'd2, 5'd0, -3));
    emit(rType(isaPkg::F3_ADD, 7'h00, 5'd3, 5'd1, 5'd2));
    emit(rType(isaPkg::F3_ADD, 7'h20, 5'd4, 5'd3, 5'd1));
    emit(rType(isaPkg::F3_AND, 7'h00, 5'd5, 5'd4, 5'd2));
    emit(rType(isaPkg::F3_OR, 7'h00, 5'd6, 5'd5, 5'd3));
    emit(rType(isaPkg::F3_XOR, 7'h00, 5'd7, 5'd6, 5'd4));
    // -3 < 5 only when signed
    emit(rType(isaPkg::F3_SLT, 7'h00, 5'd8, 5'd2, 5'd1));
    emit(rType(isaPkg::F3_SLT, 7'h00, 5'd9, 5'd1, 5'd2));
    emit(addi(5'd10, 5'd8, -1));
    emit(rType(isaPkg::F3_ADD, 7'h00, 5'd0, 5'd1, 5'd2));
    emit(rType(isaPkg::F3_ADD, 7'h00, 5'd11, 5'd10, 5'd1));
    emit(jType(5'd0, 32'd0));
  endtask

  task automatic memoryProgram();
    clearProgram();
    emit(addi(5'd1, 5'd0, 40));
    emit(addi(5'd2, 5'd0, 123));
    emit(sType(5'd2, 5'd1, 0));
    emit(lw(5'd3, 5'd1, 0));
    emit(rType(isaPkg::F3_ADD, 7'h00, 5'd4, 5'd3, 5'd3));
    emit(sType(5'd4, 5'd1, 4));
    emit(lw(5'd5, 5'd1, 4));
    emit(sType(5'd5, 5'd1, 8));
    emit(jType(5'd0, 32'd0));
  endtask

  // Branch, its shadow of register writes, then the target
  task automatic branchGroup(input logic [2:0] f3, input pipePkg::regAddr_t rs1,
      input pipePkg::regAddr_t rs2);
    emit(bType(f3, rs1, rs2, (`CPU_BRANCH_FLUSH + 1) * 4));
    for (int i = 0; i <= `CPU_BRANCH_FLUSH; i++)
    begin
      emit(addi(5'(fillReg), 5'd0, fillReg * 3));
      fillReg++;
    end
  endtask

  task automatic branchProgram();
    clearProgram();
    emit(addi(5'd1, 5'd0, 7));
    emit(addi(5'd2, 5'd0, 7));
    emit(addi(5'd6, 5'd0, 4));
    fillReg = 10;
    branchGroup(isaPkg::F3_BEQ, 5'd1, 5'd2);
    branchGroup(isaPkg::F3_BNE, 5'd1, 5'd2);
    branchGroup(isaPkg::F3_BNE, 5'd1, 5'd6);
    branchGroup(isaPkg::F3_BEQ, 5'd1, 5'd6);
    emit(jType(5'd0, 32'd0));
  endtask

  task automatic jumpProgram();
    clearProgram();
    emit(addi(5'd1, 5'd0, 1));
    emit(jType(5'd5, 12));
    emit(addi(5'd2, 5'd0, 2));
    emit(addi(5'd3, 5'd0, 3));
    emit(addi(5'd4, 5'd5, 0));
    emit(jType(5'd0, 8));
    emit(addi(5'd6, 5'd0, 6));
    emit(rType(isaPkg::F3_ADD, 7'h00, 5'd7, 5'd4, 5'd1));
    emit(jType(5'd0, 32'd0));
  endtask

  task automatic randomProgram();
    int kind;
    int sel;
    pipePkg::regAddr_t rd, rs1, rs2;
    clearProgram();
    // Fill the eight-word window before any load
    for (int i = 1; i <= 8; i++)
      emit(addi(5'(i), 5'd0, nextBits(12)));
    for (int i = 0; i < 8; i++)
      emit(sType(5'(i + 1), 5'd0, 32'(i * 4)));
    for (int n = 0; n < RANDOM_COUNT; n++)
    begin
      kind = nextBits(3);
      rd = 5'(nextBits(4));
      rs1 = 5'(nextBits(4));
      rs2 = 5'(nextBits(4));
      case (kind)
        0, 1, 2, 3:
        begin
          sel = nextBits(3) % 6;
          case (sel)
            0:       emit(rType(isaPkg::F3_ADD, 7'h00, rd, rs1, rs2));
            1:       emit(rType(isaPkg::F3_ADD, 7'h20, rd, rs1, rs2));
            2:       emit(rType(isaPkg::F3_AND, 7'h00, rd, rs1, rs2));
            3:       emit(rType(isaPkg::F3_OR, 7'h00, rd, rs1, rs2));
            4:       emit(rType(isaPkg::F3_XOR, 7'h00, rd, rs1, rs2));
            default: emit(rType(isaPkg::F3_SLT, 7'h00, rd, rs1, rs2));
          endcase
        end
        4, 5:    emit(addi(rd, rs1, nextBits(12)));
        6:       emit(lw(rd, 5'd0, nextBits(3) * 4));
        default: emit(sType(rs2, 5'd0, nextBits(3) * 4));
      endcase
    end
    emit(jType(5'd0, 32'd0));
  endtask

  // x1 is read before it is written, so stale registers would show
  task automatic restartProgram();
    clearProgram();
    emit(addi(5'd1, 5'd1, 3));
    emit(addi(5'd2, 5'd1, 4));
    emit(rType(isaPkg::F3_ADD, 7'h00, 5'd3, 5'd2, 5'd1));
    emit(rType(isaPkg::F3_ADD, 7'h20, 5'd4, 5'd3, 5'd2));
    emit(rType(isaPkg::F3_XOR, 7'h00, 5'd5, 5'd4, 5'd1));
    emit(rType(isaPkg::F3_OR, 7'h00, 5'd6, 5'd5, 5'd2));
    emit(rType(isaPkg::F3_AND, 7'h00, 5'd7, 5'd6, 5'd3));
    emit(addi(5'd8, 5'd7, 1));
    emit(jType(5'd0, 32'd0));
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, a test stopped making progress");
    $display("Done: errors found");
    $finish;
  end

  initial
  begin
    clock = 1'b0;
    reset = 1'b0;
    clearProgram();
    holdReset();
    chainProgram();
    runProgram("alu chain", 0);
    holdReset();
    memoryProgram();
    runProgram("store then load", 0);
    holdReset();
    branchProgram();
    runProgram("branches", 0);
    holdReset();
    jumpProgram();
    runProgram("jal", 0);
    holdReset();
    randomProgram();
    runProgram("random program", 0);
    holdReset();
    restartProgram();
    runProgram("reset restart", 3);
    $display("%0d tests, %0d failed, %0d pulses checked, %0d errors",
             TEST_COUNT, failedTests, checked, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

//--- tb.f
+incdir+.
isaPkg.sv
pipePkg.sv
hazardIf.sv
decoder.sv
alu.sv
regFile.sv
bypassUnit.sv
hazardUnit.sv
dataMemory.sv
cpu.sv
tbCpu.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f tb.f --top-module tbCpu -o simCpu
	./obj_dir/simCpu > sim.log
	cat sim.log
	! grep -q "Done: errors found" sim.log

clean:
	rm -rf obj_dir sim.log
